//--- dv/execTests.txt
# name instruction rsData rtData result writesReg destReg hi lo
# All columns after the name are hex; hi and lo are the values after the test.
adduWrap      00221821 FFFFFFF0 00000020 00000010 1 03 00000000 00000000
subuNeg       00222023 00000005 00000007 FFFFFFFE 1 04 00000000 00000000
andiZext      30A6F0F0 FFFF1234 00000000 00001030 1 06 00000000 00000000
oriZext       34E88000 00000001 DEADBEEF 00008001 1 08 00000000 00000000
xoriZext      392AFFFF 12345678 00000000 1234A987 1 0A 00000000 00000000
addiuNeg      242BFFFC 00000010 00000000 0000000C 1 0B 00000000 00000000
lui           3C0CABCD 55555555 00000000 ABCD0000 1 0C 00000000 00000000
sllFixed      00026900 00000000 8000000F 000000F0 1 0D 00000000 00000000
srlFixed      00027202 00000000 F0000000 00F00000 1 0E 00000000 00000000
sraFixed      00027A03 00000000 F0000000 FFF00000 1 0F 00000000 00000000
sllvMask      00228004 00000024 00000003 00000030 1 10 00000000 00000000
srlvMask      00228806 FFFFFFE8 80000000 00800000 1 11 00000000 00000000
sravMask      00229007 00000044 80000000 F8000000 1 12 00000000 00000000
sltMixed      0022982A FFFFFFFF 00000001 00000001 1 13 00000000 00000000
sltuMixed     0022A02B FFFFFFFF 00000001 00000000 1 14 00000000 00000000
sltiMixed     2835FFFF 00000001 00000000 00000000 1 15 00000000 00000000
sltiuMixed    2C36FFFF 00000001 00000000 00000001 1 16 00000000 00000000
multNeg       00220018 80000001 FFFFFFFD 00000000 0 00 00000001 7FFFFFFD
multuLarge    00220019 FFFFFFFF FFFFFFFF 00000000 0 00 FFFFFFFE 00000001
divNeg        0022001A FFFFFFF9 00000002 00000000 0 00 FFFFFFFF FFFFFFFD
divu          0022001B FFFFFFF9 00000010 00000000 0 00 00000009 0FFFFFFF
divZero       0022001A 12345678 00000000 00000000 0 00 00000009 0FFFFFFF
mfhi          0000B810 00000000 00000000 00000009 1 17 00000009 0FFFFFFF
mflo          0000C012 00000000 00000000 0FFFFFFF 1 18 00000009 0FFFFFFF
mthi          00200011 CAFEF00D 00000000 00000000 0 00 CAFEF00D 0FFFFFFF
mtlo          00200013 0BADC0DE 00000000 00000000 0 00 CAFEF00D 0BADC0DE
mfloAfterMtlo 0000C812 00000000 00000000 0BADC0DE 1 19 CAFEF00D 0BADC0DE
unknownOp     FC000000 11111111 22222222 00000000 0 00 CAFEF00D 0BADC0DE
unknownFunct  0022003F 11111111 22222222 00000000 0 00 CAFEF00D 0BADC0DE

//--- dv/execUnitTb.sv
`default_nettype none

module execUnitTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod     = 8;
    localparam int CyclesPerTest = 20;

    logic             clk = 1'b0;
    logic             rstN;
    logic             instrValid;
    mipsPkg::wordT    instruction;
    mipsPkg::wordT    rsData;
    mipsPkg::wordT    rtData;
    logic             resultValid;
    mipsPkg::wordT    result;
    logic             writesReg;
    mipsPkg::regAddrT destReg;
    mipsPkg::wordT    hi;
    mipsPkg::wordT    lo;

    // One entry per line of the tests file.
    string            tName[$];
    mipsPkg::wordT    tInstr[$];
    mipsPkg::wordT    tRs[$];
    mipsPkg::wordT    tRt[$];
    mipsPkg::wordT    tResult[$];
    logic             tWrites[$];
    mipsPkg::regAddrT tDest[$];
    mipsPkg::wordT    tHi[$];
    mipsPkg::wordT    tLo[$];
    logic             loaded = 1'b0;

    always #(ClkPeriod / 2) clk = ~clk;

    execUnit uut (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instruction (instruction),
        .rsData      (rsData),
        .rtData      (rtData),
        .resultValid (resultValid),
        .result      (result),
        .writesReg   (writesReg),
        .destReg     (destReg),
        .hi          (hi),
        .lo          (lo)
    );

    task automatic checkWord(input string testName, input string field,
                             input mipsPkg::wordT expected, input mipsPkg::wordT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: test %s, %s expected %h, actual %h",
                     testName, field, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic checkReg(input string testName, input string field,
                            input mipsPkg::regAddrT expected, input mipsPkg::regAddrT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: test %s, %s expected %h, actual %h",
                     testName, field, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic checkBit(input string testName, input string field,
                            input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: test %s, %s expected %b, actual %b",
                     testName, field, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    // Idle outputs straight out of reset.
    task automatic checkReset();
        checkBit("reset", "resultValid", 1'b0, resultValid);
        checkBit("reset", "writesReg", 1'b0, writesReg);
        checkWord("reset", "result", 32'h0000_0000, result);
        checkReg("reset", "destReg", 5'd0, destReg);
        checkWord("reset", "hi", 32'h0000_0000, hi);
        checkWord("reset", "lo", 32'h0000_0000, lo);
    endtask

    task automatic loadTests();
        int          fd;
        int          code;
        bit          done;
        string       tok;
        string       rest;
        logic [31:0] fInstr;
        logic [31:0] fRs;
        logic [31:0] fRt;
        logic [31:0] fRes;
        logic [31:0] fWr;
        logic [31:0] fDest;
        logic [31:0] fHi;
        logic [31:0] fLo;
        fd = $fopen("dv/execTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/execTests.txt for reading.");
            $display("TESTS FAILED");
            $fatal(1, "Missing tests file.");
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tok.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));  // Comment line.
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   fInstr, fRs, fRt, fRes, fWr, fDest, fHi, fLo);
                    if (code != 8) begin
                        $display("Test %s in dv/execTests.txt has missing columns.", tok);
                        $display("TESTS FAILED");
                        $fatal(1, "Bad tests file.");
                    end else begin
                        tName.push_back(tok);
                        tInstr.push_back(fInstr);
                        tRs.push_back(fRs);
                        tRt.push_back(fRt);
                        tResult.push_back(fRes);
                        tWrites.push_back(fWr[0]);
                        tDest.push_back(fDest[4:0]);
                        tHi.push_back(fHi);
                        tLo.push_back(fLo);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Issue one instruction, then look at the registered outputs.
    task automatic applyTest(input int idx);
        @(posedge clk);
        instrValid  <= 1'b1;
        instruction <= tInstr[idx];
        rsData      <= tRs[idx];
        rtData      <= tRt[idx];
        @(posedge clk);
        instrValid  <= 1'b0;
        @(negedge clk);
        checkBit(tName[idx], "resultValid", 1'b1, resultValid);
        checkWord(tName[idx], "result", tResult[idx], result);
        checkBit(tName[idx], "writesReg", tWrites[idx], writesReg);
        checkReg(tName[idx], "destReg", tDest[idx], destReg);
        checkWord(tName[idx], "hi", tHi[idx], hi);
        checkWord(tName[idx], "lo", tLo[idx], lo);
    endtask

    initial begin
        rstN        <= 1'b0;
        instrValid  <= 1'b0;
        instruction <= '0;
        rsData      <= '0;
        rtData      <= '0;
        loadTests();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkReset();
        for (int i = 0; i < tName.size(); i++) begin
            applyTest(i);
        end
        @(posedge clk);
        @(negedge clk);
        checkBit("idle", "resultValid", 1'b0, resultValid);  // No instruction, no result.
        if (tName.size() == 0) begin
            $display("The tests file held no tests.");
            $display("TESTS FAILED");
            $fatal(1, "Empty tests file.");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    initial begin
        wait (loaded);
        #((tName.size() * CyclesPerTest + 100) * ClkPeriod);
        $display("Timeout: the tests did not finish in the expected time.");
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired.");
    end

endmodule

`default_nettype wire

//--- list.f
src/mipsPkg.sv
src/decodeIf.sv
src/instrDecoder.sv
src/aluCore.sv
src/mulDivUnit.sv
src/hiLoRegs.sv
src/execUnit.sv
dv/execUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute-stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/1ps -f list.f --top-module execUnitTb -o execSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus."
    exit 1
fi

./obj_dir/execSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus."
    exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

//--- src/aluCore.sv
`default_nettype none

module aluCore (
    decodeIf.sink          dec,
    input  mipsPkg::wordT  rsData,
    input  mipsPkg::wordT  rtData,
    input  mipsPkg::wordT  hi,
    input  mipsPkg::wordT  lo,
    output mipsPkg::wordT  result
);

    mipsPkg::wordT opB;
    logic          lessSigned;
    logic          lessUnsigned;

    assign opB = dec.useImm ? dec.imm : rtData;

    // Plain two's-complement compares.
    assign lessSigned   = $signed(rsData) < $signed(opB);
    assign lessUnsigned = rsData < opB;

    always_comb begin
        case (dec.aluOp)
            mipsPkg::AluAdd: begin
                result = rsData + opB;  // Wraps modulo 2^32.
            end
            mipsPkg::AluSub: begin
                result = rsData - opB;
            end
            mipsPkg::AluAnd: begin
                result = rsData & opB;
            end
            mipsPkg::AluOr: begin
                result = rsData | opB;
            end
            mipsPkg::AluXor: begin
                result = rsData ^ opB;
            end
            mipsPkg::AluLui: begin
                result = {dec.imm[15:0], 16'h0000};
            end
            mipsPkg::AluSll: begin
                result = rtData << dec.shamt;
            end
            mipsPkg::AluSrl: begin
                result = rtData >> dec.shamt;
            end
            mipsPkg::AluSra: begin
                result = $signed(rtData) >>> dec.shamt;
            end
            mipsPkg::AluSlt: begin
                result = {31'd0, lessSigned};
            end
            mipsPkg::AluSltu: begin
                result = {31'd0, lessUnsigned};
            end
            mipsPkg::AluPassHi: begin
                result = hi;
            end
            mipsPkg::AluPassLo: begin
                result = lo;
            end
            default: begin
                result = '0;  // AluNone and unknown codes.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/decodeIf.sv
`default_nettype none

interface decodeIf;

    mipsPkg::aluOpE    aluOp;
    mipsPkg::mulDivOpE mdOp;
    logic              useImm;     // Operand B is imm, not rtData.
    mipsPkg::wordT     imm;        // Already extended.
    logic [4:0]        shamt;
    logic              writesReg;
    mipsPkg::regAddrT  destReg;

    modport source (
        output aluOp,
        output mdOp,
        output useImm,
        output imm,
        output shamt,
        output writesReg,
        output destReg
    );

    modport sink (
        input aluOp,
        input mdOp,
        input useImm,
        input imm,
        input shamt,
        input writesReg,
        input destReg
    );

endinterface

`default_nettype wire

//--- src/execUnit.sv
`default_nettype none

module execUnit (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  mipsPkg::wordT     instruction,
    input  mipsPkg::wordT     rsData,
    input  mipsPkg::wordT     rtData,
    output logic              resultValid,
    output mipsPkg::wordT     result,
    output logic              writesReg,
    output mipsPkg::regAddrT  destReg,
    output mipsPkg::wordT     hi,
    output mipsPkg::wordT     lo
);

    decodeIf dec ();

    mipsPkg::wordT aluResult;
    logic          hiWrite;
    logic          loWrite;
    mipsPkg::wordT hiNext;
    mipsPkg::wordT loNext;

    instrDecoder uDecoder (
        .instruction (instruction),
        .rsData      (rsData),
        .dec         (dec.source)
    );

    aluCore uAlu (
        .dec    (dec.sink),
        .rsData (rsData),
        .rtData (rtData),
        .hi     (hi),
        .lo     (lo),
        .result (aluResult)
    );

    mulDivUnit uMulDiv (
        .dec     (dec.sink),
        .rsData  (rsData),
        .rtData  (rtData),
        .hi      (hi),
        .lo      (lo),
        .hiWrite (hiWrite),
        .loWrite (loWrite),
        .hiNext  (hiNext),
        .loNext  (loNext)
    );

    hiLoRegs uHiLo (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .hiWrite    (hiWrite),
        .loWrite    (loWrite),
        .hiNext     (hiNext),
        .loNext     (loNext),
        .hi         (hi),
        .lo         (lo)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            writesReg   <= 1'b0;
            result      <= '0;
            destReg     <= '0;
        end else begin
            resultValid <= instrValid;
            writesReg   <= instrValid && dec.writesReg;
            if (instrValid) begin
                result  <= aluResult;
                destReg <= dec.destReg;
            end
        end
    end

    // A valid instruction word must be fully known.
    assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> !$isunknown(instruction))
        else $error("Instruction word unknown with instrValid high.");

endmodule

`default_nettype wire

//--- src/hiLoRegs.sv
`default_nettype none

module hiLoRegs (
    input  logic           clk,
    input  logic           rstN,
    input  logic           instrValid,
    input  logic           hiWrite,
    input  logic           loWrite,
    input  mipsPkg::wordT  hiNext,
    input  mipsPkg::wordT  loNext,
    output mipsPkg::wordT  hi,
    output mipsPkg::wordT  lo
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
        end else if (instrValid && hiWrite) begin
            hi <= hiNext;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lo <= '0;
        end else if (instrValid && loWrite) begin
            lo <= loNext;
        end
    end

    // A valid instruction must reach here with clean strobes.
    assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> !$isunknown({hiWrite, loWrite}))
        else $error("HI/LO write strobes unknown with instrValid high.");

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
`default_nettype none

module instrDecoder (
    input  mipsPkg::wordT instruction,
    input  mipsPkg::wordT rsData,
    decodeIf.source       dec
);

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic [4:0]       shamtField;
    logic [15:0]      immField;
    mipsPkg::regAddrT rtField;
    mipsPkg::regAddrT rdField;
    logic             signExt;

    assign opcode     = instruction[31:26];
    assign rtField    = instruction[20:16];
    assign rdField    = instruction[15:11];
    assign shamtField = instruction[10:6];
    assign funct      = instruction[5:0];
    assign immField   = instruction[15:0];

    always_comb begin
        dec.aluOp     = mipsPkg::AluNone;
        dec.mdOp      = mipsPkg::MdNone;
        dec.useImm    = 1'b0;
        dec.shamt     = shamtField;
        dec.writesReg = 1'b0;
        dec.destReg   = rdField;
        signExt       = 1'b0;
        case (opcode)
            mipsPkg::OpSpecial: begin
                dec.writesReg = 1'b1;
                case (funct)
                    mipsPkg::FnSll:  dec.aluOp = mipsPkg::AluSll;
                    mipsPkg::FnSrl:  dec.aluOp = mipsPkg::AluSrl;
                    mipsPkg::FnSra:  dec.aluOp = mipsPkg::AluSra;
                    mipsPkg::FnSllv: begin
                        dec.aluOp = mipsPkg::AluSll;
                        dec.shamt = rsData[4:0];
                    end
                    mipsPkg::FnSrlv: begin
                        dec.aluOp = mipsPkg::AluSrl;
                        dec.shamt = rsData[4:0];
                    end
                    mipsPkg::FnSrav: begin
                        dec.aluOp = mipsPkg::AluSra;
                        dec.shamt = rsData[4:0];
                    end
                    mipsPkg::FnMfhi: dec.aluOp = mipsPkg::AluPassHi;
                    mipsPkg::FnMflo: dec.aluOp = mipsPkg::AluPassLo;
                    mipsPkg::FnAddu: dec.aluOp = mipsPkg::AluAdd;
                    mipsPkg::FnSubu: dec.aluOp = mipsPkg::AluSub;
                    mipsPkg::FnAnd:  dec.aluOp = mipsPkg::AluAnd;
                    mipsPkg::FnOr:   dec.aluOp = mipsPkg::AluOr;
                    mipsPkg::FnXor:  dec.aluOp = mipsPkg::AluXor;
                    mipsPkg::FnSlt:  dec.aluOp = mipsPkg::AluSlt;
                    mipsPkg::FnSltu: dec.aluOp = mipsPkg::AluSltu;
                    mipsPkg::FnMthi: begin
                        dec.mdOp      = mipsPkg::MdToHi;
                        dec.writesReg = 1'b0;
                    end
                    mipsPkg::FnMtlo: begin
                        dec.mdOp      = mipsPkg::MdToLo;
                        dec.writesReg = 1'b0;
                    end
                    mipsPkg::FnMult: begin
                        dec.mdOp      = mipsPkg::MdMult;
                        dec.writesReg = 1'b0;
                    end
                    mipsPkg::FnMultu: begin
                        dec.mdOp      = mipsPkg::MdMultu;
                        dec.writesReg = 1'b0;
                    end
                    mipsPkg::FnDiv: begin
                        dec.mdOp      = mipsPkg::MdDiv;
                        dec.writesReg = 1'b0;
                    end
                    mipsPkg::FnDivu: begin
                        dec.mdOp      = mipsPkg::MdDivu;
                        dec.writesReg = 1'b0;
                    end
                    default: dec.writesReg = 1'b0;  // Unknown function.
                endcase
            end
            mipsPkg::OpAddiu: begin
                dec.aluOp = mipsPkg::AluAdd;
                signExt   = 1'b1;
            end
            mipsPkg::OpSlti: begin
                dec.aluOp = mipsPkg::AluSlt;
                signExt   = 1'b1;
            end
            mipsPkg::OpSltiu: begin
                dec.aluOp = mipsPkg::AluSltu;
                signExt   = 1'b1;  // Sign-extended, then compared unsigned.
            end
            mipsPkg::OpAndi: dec.aluOp = mipsPkg::AluAnd;
            mipsPkg::OpOri:  dec.aluOp = mipsPkg::AluOr;
            mipsPkg::OpXori: dec.aluOp = mipsPkg::AluXor;
            mipsPkg::OpLui:  dec.aluOp = mipsPkg::AluLui;
            default: dec.aluOp = mipsPkg::AluNone;
        endcase
        if (opcode != mipsPkg::OpSpecial && dec.aluOp != mipsPkg::AluNone) begin
            dec.useImm    = 1'b1;  // I-type writes rt.
            dec.writesReg = 1'b1;
            dec.destReg   = rtField;
        end
        dec.imm = signExt ? {{16{immField[15]}}, immField} : {16'h0000, immField};
    end

endmodule

`default_nettype wire

//--- src/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // Primary opcode field, instruction[31:26].
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpSlti    = 6'h0A;
    localparam logic [5:0] OpSltiu   = 6'h0B;
    localparam logic [5:0] OpAndi    = 6'h0C;
    localparam logic [5:0] OpOri     = 6'h0D;
    localparam logic [5:0] OpXori    = 6'h0E;
    localparam logic [5:0] OpLui     = 6'h0F;

    // Function field of SPECIAL, instruction[5:0].
    localparam logic [5:0] FnSll   = 6'h00;
    localparam logic [5:0] FnSrl   = 6'h02;
    localparam logic [5:0] FnSra   = 6'h03;
    localparam logic [5:0] FnSllv  = 6'h04;
    localparam logic [5:0] FnSrlv  = 6'h06;
    localparam logic [5:0] FnSrav  = 6'h07;
    localparam logic [5:0] FnMfhi  = 6'h10;
    localparam logic [5:0] FnMthi  = 6'h11;
    localparam logic [5:0] FnMflo  = 6'h12;
    localparam logic [5:0] FnMtlo  = 6'h13;
    localparam logic [5:0] FnMult  = 6'h18;
    localparam logic [5:0] FnMultu = 6'h19;
    localparam logic [5:0] FnDiv   = 6'h1A;
    localparam logic [5:0] FnDivu  = 6'h1B;
    localparam logic [5:0] FnAddu  = 6'h21;
    localparam logic [5:0] FnSubu  = 6'h23;
    localparam logic [5:0] FnAnd   = 6'h24;
    localparam logic [5:0] FnOr    = 6'h25;
    localparam logic [5:0] FnXor   = 6'h26;
    localparam logic [5:0] FnSlt   = 6'h2A;
    localparam logic [5:0] FnSltu  = 6'h2B;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluLui,
        AluSll,
        AluSrl,
        AluSra,
        AluSlt,
        AluSltu,
        AluPassHi,  // MFHI.
        AluPassLo,  // MFLO.
        AluNone
    } aluOpE;

    typedef enum logic [2:0] {
        MdNone,
        MdMult,
        MdMultu,
        MdDiv,
        MdDivu,
        MdToHi,     // MTHI.
        MdToLo      // MTLO.
    } mulDivOpE;

endpackage

`default_nettype wire

//--- src/mulDivUnit.sv
`default_nettype none

module mulDivUnit (
    decodeIf.sink          dec,
    input  mipsPkg::wordT  rsData,
    input  mipsPkg::wordT  rtData,
    input  mipsPkg::wordT  hi,
    input  mipsPkg::wordT  lo,
    output logic           hiWrite,
    output logic           loWrite,
    output mipsPkg::wordT  hiNext,
    output mipsPkg::wordT  loNext
);

    logic [63:0]   prodSigned;
    logic [63:0]   prodUnsigned;
    mipsPkg::wordT quotSigned;
    mipsPkg::wordT remSigned;
    logic          divByZero;

    // Low 64 bits of a sign-extended product equal the signed product.
    assign prodSigned   = {{32{rsData[31]}}, rsData} * {{32{rtData[31]}}, rtData};
    assign prodUnsigned = {32'd0, rsData} * {32'd0, rtData};

    assign quotSigned = $signed(rsData) / $signed(rtData);  // Truncates toward zero.
    assign remSigned  = $signed(rsData) % $signed(rtData);  // Sign of the dividend.
    assign divByZero  = rtData == '0;

    always_comb begin
        hiWrite = 1'b0;
        loWrite = 1'b0;
        hiNext  = hi;
        loNext  = lo;
        case (dec.mdOp)
            mipsPkg::MdMult: begin
                {hiNext, loNext} = prodSigned;
                hiWrite          = 1'b1;
                loWrite          = 1'b1;
            end
            mipsPkg::MdMultu: begin
                {hiNext, loNext} = prodUnsigned;
                hiWrite          = 1'b1;
                loWrite          = 1'b1;
            end
            mipsPkg::MdDiv: begin
                hiNext  = remSigned;
                loNext  = quotSigned;
                hiWrite = !divByZero;
                loWrite = !divByZero;
            end
            mipsPkg::MdDivu: begin
                hiNext  = rsData % rtData;
                loNext  = rsData / rtData;
                hiWrite = !divByZero;
                loWrite = !divByZero;
            end
            mipsPkg::MdToHi: begin
                hiNext  = rsData;
                hiWrite = 1'b1;
            end
            mipsPkg::MdToLo: begin
                loNext  = rsData;
                loWrite = 1'b1;
            end
            default: begin
                hiWrite = 1'b0;
                loWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire
